// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := tb_ibuffer
RTL_TOP    := ibuffer_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
PASS_MSG   := *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+.
ibuf_pkg.sv
elastic_buffer.sv
instr_decode.sv
ibuffer.sv
ibuffer_top.sv
tb_ibuffer.sv

// File: elastic_buffer.sv
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATAW = 8,
    parameter int SIZE  = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);

    // the output register holds one entry, the ring holds the rest
    localparam int DEPTH = SIZE - 1;
    localparam int ADDRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW  = $clog2(SIZE + 1);

    logic [DATAW-1:0] mem [DEPTH];
    logic [ADDRW-1:0] rd_ptr;
    logic [ADDRW-1:0] wr_ptr;
    logic [CNTW-1:0]  used;
    logic [CNTW-1:0]  fifo_cnt;
    logic             push;
    logic             pop;
    logic             out_load;
    logic             fifo_empty;
    logic             fifo_rd;
    logic             fifo_wr;
    logic             bypass;

    function automatic logic [ADDRW-1:0] next_ptr(input logic [ADDRW-1:0] ptr);
        if (ptr == ADDRW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    // used counts the output register too
    assign ready_in   = (used != CNTW'(SIZE));
    assign fifo_cnt   = used - CNTW'(valid_out);
    assign fifo_empty = (fifo_cnt == '0);

    // the output register can take a new entry when empty or being drained
    assign out_load = !valid_out || ready_out;

    // older entries in the ring always go first to keep order
    assign fifo_rd = out_load && !fifo_empty;
    assign bypass  = out_load && fifo_empty && push;
    assign fifo_wr = push && !bypass;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            used      <= '0;
        end else begin
            if (out_load) begin
                valid_out <= !fifo_empty || push;
            end
            if (fifo_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (fifo_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            used <= used + CNTW'(push) - CNTW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            mem[wr_ptr] <= data_in;
        end
        if (fifo_rd) begin
            data_out <= mem[rd_ptr];
        end else if (bypass) begin
            data_out <= data_in;
        end
    end

endmodule

// File: ibuf_defs.svh
`ifndef IBUF_DEFS_SVH
`define IBUF_DEFS_SVH

// core sizing

// warps per core
`define NUM_WARPS   8

// issue slots, each with its own queue
`define ISSUE_CNT   4

// lanes per warp, one tmask bit each
`define NUM_THREADS 4

// data path and PC width
`define XLEN        32

// width of the instruction trace tag
`define UUID_WIDTH  16

// register index width
`define NR_BITS     5

// derived widths

// log2 of NUM_WARPS
`define WID_BITS    3

// log2 of ISSUE_CNT, slot index taken from the low wid bits
`define ISW_BITS    2

// log2 of NUM_WARPS / ISSUE_CNT, warp index inside a slot
`define WIS_BITS    1

// decoded operation fields
`define EX_BITS     2
`define OP_BITS     3
`define MOD_BITS    1

// two entries per warp that shares a slot
`define IBUF_SIZE   (2 * `NUM_WARPS / `ISSUE_CNT)

`endif

// File: ibuf_pkg.sv
`include "ibuf_defs.svh"

package ibuf_pkg;

    // ALU opcodes the decoder understands
    localparam logic [6:0] OPC_R = 7'h33;
    localparam logic [6:0] OPC_I = 7'h13;

    typedef enum logic [`EX_BITS-1:0] {
        EX_NOP = 2'd0,
        EX_ALU = 2'd1
    } ex_type_e;

    // register-register layout
    typedef struct packed {
        logic [6:0]          funct7;
        logic [`NR_BITS-1:0] rs2;
        logic [`NR_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [`NR_BITS-1:0] rd;
        logic [6:0]          opcode;
    } r_fmt_t;

    // register-immediate layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0]         imm12;
        logic [`NR_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [`NR_BITS-1:0] rd;
        logic [6:0]          opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [`WID_BITS-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        ex_type_e                ex_type;
        logic [`OP_BITS-1:0]     op_type;
        logic [`MOD_BITS-1:0]    op_mod;
        logic                    wb;
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        imm;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic [`NR_BITS-1:0]     rs3;
    } decoded_instr_t;

    // queue payload, the slot index is implied by the lane
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [`WIS_BITS-1:0]    wis;
        logic [`NUM_THREADS-1:0] tmask;
        ex_type_e                ex_type;
        logic [`OP_BITS-1:0]     op_type;
        logic [`MOD_BITS-1:0]    op_mod;
        logic                    wb;
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        imm;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic [`NR_BITS-1:0]     rs3;
    } issue_instr_t;

endpackage

// File: ibuffer.sv
`timescale 1ns/1ps

`include "ibuf_defs.svh"

module ibuffer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    decode_valid,
    output logic                                    decode_ready,
    input  ibuf_pkg::decoded_instr_t                decode_data,
    output logic [`ISSUE_CNT-1:0]                   ibuf_valid,
    input  logic [`ISSUE_CNT-1:0]                   ibuf_ready,
    output ibuf_pkg::issue_instr_t [`ISSUE_CNT-1:0] ibuf_data,
    output logic [`ISSUE_CNT-1:0]                   ibuf_pop
);

    import ibuf_pkg::*;

    localparam int DATAW = $bits(issue_instr_t);

    logic [`ISW_BITS-1:0]  decode_isw;
    logic [`WIS_BITS-1:0]  decode_wis;
    logic [`ISSUE_CNT-1:0] slot_ready;
    issue_instr_t          issue_rec;

    // ISSUE_CNT is a power of two, so mod and div are bit slices of wid
    assign decode_isw = decode_data.wid[`ISW_BITS-1:0];
    assign decode_wis = decode_data.wid[`WID_BITS-1:`ISW_BITS];

    always_comb begin
        issue_rec.uuid    = decode_data.uuid;
        issue_rec.wis     = decode_wis;
        issue_rec.tmask   = decode_data.tmask;
        issue_rec.ex_type = decode_data.ex_type;
        issue_rec.op_type = decode_data.op_type;
        issue_rec.op_mod  = decode_data.op_mod;
        issue_rec.wb      = decode_data.wb;
        issue_rec.use_pc  = decode_data.use_pc;
        issue_rec.use_imm = decode_data.use_imm;
        issue_rec.pc      = decode_data.pc;
        issue_rec.imm     = decode_data.imm;
        issue_rec.rd      = decode_data.rd;
        issue_rec.rs1     = decode_data.rs1;
        issue_rec.rs2     = decode_data.rs2;
        issue_rec.rs3     = decode_data.rs3;
    end

    // a full slot only holds back the word that targets it
    assign decode_ready = slot_ready[decode_isw];

    for (genvar i = 0; i < `ISSUE_CNT; i++) begin : g_slot
        elastic_buffer #(
            .DATAW (DATAW),
            .SIZE  (`IBUF_SIZE)
        ) i_buf (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (decode_valid && (decode_isw == `ISW_BITS'(i))),
            .ready_in  (slot_ready[i]),
            .data_in   (issue_rec),
            .valid_out (ibuf_valid[i]),
            .ready_out (ibuf_ready[i]),
            .data_out  (ibuf_data[i])
        );

        // tells the scheduler an entry left this slot
        assign ibuf_pop[i] = ibuf_valid[i] && ibuf_ready[i];
    end

endmodule

// File: ibuffer_top.sv
`timescale 1ns/1ps

`include "ibuf_defs.svh"

module ibuffer_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    fetch_valid,
    output logic                                    fetch_ready,
    input  ibuf_pkg::instr_word_u                   fetch_instr,
    input  logic [`WID_BITS-1:0]                    fetch_wid,
    input  logic [`NUM_THREADS-1:0]                 fetch_tmask,
    input  logic [`XLEN-1:0]                        fetch_pc,
    input  logic [`UUID_WIDTH-1:0]                  fetch_uuid,
    output logic [`ISSUE_CNT-1:0]                   ibuf_valid,
    input  logic [`ISSUE_CNT-1:0]                   ibuf_ready,
    output ibuf_pkg::issue_instr_t [`ISSUE_CNT-1:0] ibuf_data,
    output logic [`ISSUE_CNT-1:0]                   ibuf_pop
);

    import ibuf_pkg::*;

    logic           decode_valid;
    logic           decode_ready;
    decoded_instr_t decode_data;

    instr_decode i_decode (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_instr  (fetch_instr),
        .fetch_wid    (fetch_wid),
        .fetch_tmask  (fetch_tmask),
        .fetch_pc     (fetch_pc),
        .fetch_uuid   (fetch_uuid),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data)
    );

    ibuffer i_ibuffer (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data),
        .ibuf_valid   (ibuf_valid),
        .ibuf_ready   (ibuf_ready),
        .ibuf_data    (ibuf_data),
        .ibuf_pop     (ibuf_pop)
    );

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps

`include "ibuf_defs.svh"

module instr_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  ibuf_pkg::instr_word_u   fetch_instr,
    input  logic [`WID_BITS-1:0]    fetch_wid,
    input  logic [`NUM_THREADS-1:0] fetch_tmask,
    input  logic [`XLEN-1:0]        fetch_pc,
    input  logic [`UUID_WIDTH-1:0]  fetch_uuid,
    output logic                    decode_valid,
    input  logic                    decode_ready,
    output ibuf_pkg::decoded_instr_t decode_data
);

    import ibuf_pkg::*;

    decoded_instr_t dec;
    logic           active;
    logic           fetch_fire;

    // goes high on the first edge after reset, so fetch_ready stays low in reset
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // take a word when the stage is empty or its content leaves this cycle
    assign fetch_ready = active && (!decode_valid || decode_ready);
    assign fetch_fire  = fetch_valid && fetch_ready;

    // fields a format does not use stay zero, so a NOP is all zero
    // apart from its tags
    always_comb begin
        dec       = '0;
        dec.uuid  = fetch_uuid;
        dec.wid   = fetch_wid;
        dec.tmask = fetch_tmask;
        dec.pc    = fetch_pc;
        dec.ex_type = EX_NOP;
        case (fetch_instr.r_fmt.opcode)
            OPC_R: begin
                dec.ex_type = EX_ALU;
                dec.op_type = fetch_instr.r_fmt.funct3;
                dec.op_mod  = fetch_instr.r_fmt.funct7[5];
                dec.rd      = fetch_instr.r_fmt.rd;
                dec.rs1     = fetch_instr.r_fmt.rs1;
                dec.rs2     = fetch_instr.r_fmt.rs2;
                dec.wb      = (fetch_instr.r_fmt.rd != '0);
            end
            OPC_I: begin
                dec.ex_type = EX_ALU;
                dec.op_type = fetch_instr.i_fmt.funct3;
                dec.use_imm = 1'b1;
                dec.imm     = {{(`XLEN-12){fetch_instr.i_fmt.imm12[11]}},
                               fetch_instr.i_fmt.imm12};
                dec.rd      = fetch_instr.i_fmt.rd;
                dec.rs1     = fetch_instr.i_fmt.rs1;
                dec.wb      = (fetch_instr.i_fmt.rd != '0);
            end
            default: begin
                dec.ex_type = EX_NOP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_valid <= 1'b0;
        end else if (fetch_ready) begin
            decode_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            decode_data <= dec;
        end
    end

endmodule

// File: tb_ibuffer.sv
`timescale 1ns/1ps

`include "ibuf_defs.svh"

module tb_ibuffer;

    import ibuf_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_FETCH   = 600;
    localparam int WATCHDOG_NS = NUM_FETCH * 20 * CLK_PERIOD;
    localparam int STALL_SLOT  = 2;

    logic                           clk;
    logic                           reset;
    logic                           fetch_valid;
    logic                           fetch_ready;
    instr_word_u                    fetch_instr;
    logic [`WID_BITS-1:0]           fetch_wid;
    logic [`NUM_THREADS-1:0]        fetch_tmask;
    logic [`XLEN-1:0]               fetch_pc;
    logic [`UUID_WIDTH-1:0]         fetch_uuid;
    logic [`ISSUE_CNT-1:0]          ibuf_valid;
    logic [`ISSUE_CNT-1:0]          ibuf_ready;
    issue_instr_t [`ISSUE_CNT-1:0]  ibuf_data;
    logic [`ISSUE_CNT-1:0]          ibuf_pop;

    // pre-generated fetch stream, the uuid is the index
    logic [31:0]             word_mem  [NUM_FETCH];
    logic [`WID_BITS-1:0]    wid_mem   [NUM_FETCH];
    logic [`NUM_THREADS-1:0] tmask_mem [NUM_FETCH];
    logic [`XLEN-1:0]        pc_mem    [NUM_FETCH];

    // expected issue records, one queue per slot
    issue_instr_t model_q [`ISSUE_CNT][$];

    integer seed;
    int     accept_cnt;
    int     cycle_cnt;
    int     slot;
    bit     fetch_fired;

    ibuffer_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_instr (fetch_instr),
        .fetch_wid   (fetch_wid),
        .fetch_tmask (fetch_tmask),
        .fetch_pc    (fetch_pc),
        .fetch_uuid  (fetch_uuid),
        .ibuf_valid  (ibuf_valid),
        .ibuf_ready  (ibuf_ready),
        .ibuf_data   (ibuf_data),
        .ibuf_pop    (ibuf_pop)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    // reference decode straight from the bit positions of the two ALU formats
    function automatic issue_instr_t expect_issue(
        input logic [31:0]             word,
        input logic [`WID_BITS-1:0]    wid,
        input logic [`NUM_THREADS-1:0] tmask,
        input logic [`XLEN-1:0]        pc,
        input logic [`UUID_WIDTH-1:0]  uuid
    );
        issue_instr_t        e;
        logic [6:0]          opcode;
        logic [`NR_BITS-1:0] rd;
        opcode    = word[6:0];
        rd        = word[11:7];
        e         = '0;
        e.uuid    = uuid;
        e.wis     = `WIS_BITS'(wid / `ISSUE_CNT);
        e.tmask   = tmask;
        e.pc      = pc;
        e.ex_type = EX_NOP;
        if (opcode == 7'h33) begin
            e.ex_type = EX_ALU;
            e.op_type = word[14:12];
            e.op_mod  = word[30];
            e.rd      = rd;
            e.rs1     = word[19:15];
            e.rs2     = word[24:20];
            e.wb      = (rd != 0);
        end else if (opcode == 7'h13) begin
            e.ex_type = EX_ALU;
            e.op_type = word[14:12];
            e.use_imm = 1'b1;
            e.imm     = {{(`XLEN - 12){word[31]}}, word[31:20]};
            e.rd      = rd;
            e.rs1     = word[19:15];
            e.wb      = (rd != 0);
        end
        return e;
    endfunction

    task automatic compare_field(input int slot_idx, input string name,
                                 input logic [63:0] expected, input logic [63:0] got);
        if (expected !== got) begin
            report_error($sformatf("mismatch ibuf_data[%0d].%s expected 0x%0h got 0x%0h",
                                   slot_idx, name, expected, got));
        end
    endtask

    task automatic check_instr(input int slot_idx, input issue_instr_t got);
        issue_instr_t exp;
        if (model_q[slot_idx].size() == 0) begin
            report_error($sformatf("slot %0d issued an instruction that was never fetched",
                                   slot_idx));
        end else begin
            exp = model_q[slot_idx].pop_front();
            compare_field(slot_idx, "uuid", 64'(exp.uuid), 64'(got.uuid));
            compare_field(slot_idx, "wis", 64'(exp.wis), 64'(got.wis));
            compare_field(slot_idx, "tmask", 64'(exp.tmask), 64'(got.tmask));
            compare_field(slot_idx, "ex_type", 64'(exp.ex_type), 64'(got.ex_type));
            compare_field(slot_idx, "op_type", 64'(exp.op_type), 64'(got.op_type));
            compare_field(slot_idx, "op_mod", 64'(exp.op_mod), 64'(got.op_mod));
            compare_field(slot_idx, "wb", 64'(exp.wb), 64'(got.wb));
            compare_field(slot_idx, "use_pc", 64'(exp.use_pc), 64'(got.use_pc));
            compare_field(slot_idx, "use_imm", 64'(exp.use_imm), 64'(got.use_imm));
            compare_field(slot_idx, "pc", 64'(exp.pc), 64'(got.pc));
            compare_field(slot_idx, "imm", 64'(exp.imm), 64'(got.imm));
            compare_field(slot_idx, "rd", 64'(exp.rd), 64'(got.rd));
            compare_field(slot_idx, "rs1", 64'(exp.rs1), 64'(got.rs1));
            compare_field(slot_idx, "rs2", 64'(exp.rs2), 64'(got.rs2));
            compare_field(slot_idx, "rs3", 64'(exp.rs3), 64'(got.rs3));
        end
    endtask

    task automatic check_pop(input int slot_idx, input logic got);
        logic expected;
        expected = ibuf_valid[slot_idx] && ibuf_ready[slot_idx];
        if (got !== expected) begin
            report_error($sformatf("mismatch ibuf_pop[%0d] expected 0x%0h got 0x%0h",
                                   slot_idx, expected, got));
        end
    endtask

    // 45 % R-type, 45 % I-type, the rest any other opcode
    task automatic gen_stimulus();
        int         pick;
        logic [6:0] opcode;
        for (int n = 0; n < NUM_FETCH; n++) begin
            pick = int'($unsigned($random(seed)) % 100);
            if (pick < 45) begin
                opcode = 7'h33;
            end else if (pick < 90) begin
                opcode = 7'h13;
            end else begin
                do begin
                    opcode = 7'($random(seed));
                end while (opcode == 7'h33 || opcode == 7'h13);
            end
            word_mem[n]  = {25'($random(seed)), opcode};
            wid_mem[n]   = `WID_BITS'($random(seed));
            tmask_mem[n] = `NUM_THREADS'($random(seed));
            pc_mem[n]    = `XLEN'($random(seed));
        end
    endtask

    function automatic logic lane_ready(input int lane);
        if (accept_cnt < 200) begin
            return ($unsigned($random(seed)) % 100) < 70;
        end else if (accept_cnt < 400) begin
            // one slot opens only briefly every 50 cycles
            if (lane == STALL_SLOT) begin
                return (cycle_cnt % 50) >= 44;
            end
            return ($unsigned($random(seed)) % 100) < 60;
        end
        return 1'b1;
    endfunction

    task automatic drive_cycle();
        // a word offered and not taken stays on the bus unchanged
        if (!(fetch_valid && !fetch_fired)) begin
            if (accept_cnt < NUM_FETCH && ($unsigned($random(seed)) % 100) < 80) begin
                fetch_valid = 1'b1;
                fetch_instr = word_mem[accept_cnt];
                fetch_wid   = wid_mem[accept_cnt];
                fetch_tmask = tmask_mem[accept_cnt];
                fetch_pc    = pc_mem[accept_cnt];
                fetch_uuid  = `UUID_WIDTH'(accept_cnt);
            end else begin
                fetch_valid = 1'b0;
            end
        end
        for (int s = 0; s < `ISSUE_CNT; s++) begin
            ibuf_ready[s] = lane_ready(s);
        end
        cycle_cnt++;
    endtask

    function automatic bit queues_empty();
        for (int s = 0; s < `ISSUE_CNT; s++) begin
            if (model_q[s].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // sample half a cycle after the drive point, when everything has settled
    always @(negedge clk) begin
        fetch_fired = 1'b0;
        // only the newest accepted word can still sit in the decode stage,
        // so the older of two words for one slot must be on offer already
        for (int s = 0; s < `ISSUE_CNT; s++) begin
            if (model_q[s].size() > 1 && !ibuf_valid[s]) begin
                report_error($sformatf("slot %0d holds fetched instructions but is not valid",
                                       s));
            end
        end
        if (reset) begin
            if (fetch_ready) begin
                report_error("fetch_ready is high while reset is asserted");
            end
        end else if (fetch_valid && fetch_ready) begin
            slot = fetch_wid % `ISSUE_CNT;
            model_q[slot].push_back(expect_issue(fetch_instr, fetch_wid, fetch_tmask,
                                                 fetch_pc, fetch_uuid));
            accept_cnt++;
            fetch_fired = 1'b1;
        end
        for (int s = 0; s < `ISSUE_CNT; s++) begin
            check_pop(s, ibuf_pop[s]);
            if (ibuf_valid[s] && model_q[s].size() == 0) begin
                report_error($sformatf("slot %0d is valid but holds nothing that was fetched",
                                       s));
            end
            if (ibuf_valid[s] && ibuf_ready[s]) begin
                check_instr(s, ibuf_data[s]);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog expired before the fetch stream drained");
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_wid   = '0;
        fetch_tmask = '0;
        fetch_pc    = '0;
        fetch_uuid  = '0;
        ibuf_ready  = '0;
        seed        = 32'h9629_d9d5;
        accept_cnt  = 0;
        cycle_cnt   = 0;
        fetch_fired = 1'b0;
        gen_stimulus();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!(accept_cnt == NUM_FETCH && queues_empty())) begin
            drive_cycle();
            @(posedge clk);
            #1;
        end
        // idle a little so a stray valid would still be caught
        fetch_valid = 1'b0;
        ibuf_ready  = '1;
        repeat (10) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule
